//--- sys_pipe.f
+incdir+include
verilog/sys_pipe_pkg.sv
verilog/sys_cmd_if.sv
verilog/sys_trap_if.sv
verilog/sys_cmd_stage.sv
verilog/sys_csr_file.sv
verilog/sys_trap_ctrl.sv
verilog/sys_pipe.sv
verification/sys_pipe_tb.sv

//--- verification/sys_pipe_tb.sv
/*
  Testbench for the system pipe. Sends random CSR instructions through
  dispatch and commit, flushes, exceptions, TLB misses, interrupts and
  MRET, and checks every result against a CSR model kept here.
  Run from the project root with the sys_pipe file list.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

module sys_pipe_tb;
  import sys_pipe_pkg::*;

  localparam int status_mie_bit  = 3;
  localparam int status_mpie_bit = 7;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       sys_v_i;
  sys_op_e                    sys_op_i;
  logic [`SYS_CSR_ADDR_W-1:0] csr_addr_i;
  logic [`SYS_XLEN-1:0]       rs1_i;
  logic [`SYS_XLEN-1:0]       imm_i;
  logic                       store_i;
  logic                       flush_i;
  logic                       mem_ready_i;
  logic                       commit_v_i;
  logic [`SYS_VADDR_W-1:0]    commit_pc_i;
  logic [`SYS_VADDR_W-1:0]    commit_npc_i;
  sys_exc_s                   exception_i;
  logic [`SYS_VADDR_W-1:0]    exception_vaddr_i;
  logic                       timer_irq_i;
  logic                       software_irq_i;
  logic                       external_irq_i;
  logic                       ready_o;
  logic                       v_o;
  logic [`SYS_XLEN-1:0]       data_o;
  logic                       exc_v_o;
  logic                       miss_v_o;
  logic                       itlb_miss_o;
  logic                       load_miss_o;
  logic                       store_miss_o;
  logic [`SYS_VADDR_W-1:0]    miss_vaddr_o;
  logic                       trap_v_o;
  logic [`SYS_VADDR_W-1:0]    trap_pc_o;

  integer      seed;
  integer      mismatches;
  integer      timeouts;
  logic [63:0] m_mstatus;
  logic [63:0] m_mie;
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtval;
  logic [63:0] m_mscratch;
  logic [63:0] m_minstret;
  logic [63:0] m_last_npc;     // npc of the last retired instruction.

  sys_pipe uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    begin
      mismatches = mismatches + 1;
      $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic sys_op_e pick_op(input integer k);
    case (k)
      0:       return e_sys_rw;
      1:       return e_sys_rs;
      2:       return e_sys_rc;
      3:       return e_sys_rwi;
      4:       return e_sys_rsi;
      default: return e_sys_rci;
    endcase
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] a);
    case (a)
      `SYS_CSR_MSTATUS:  return m_mstatus;
      `SYS_CSR_MIE:      return m_mie;
      `SYS_CSR_MTVEC:    return m_mtvec;
      `SYS_CSR_MEPC:     return m_mepc;
      `SYS_CSR_MCAUSE:   return m_mcause;
      `SYS_CSR_MTVAL:    return m_mtval;
      `SYS_CSR_MSCRATCH: return m_mscratch;
      `SYS_CSR_MINSTRET: return m_minstret;
      default:           return 64'h0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] a, input logic [63:0] d);
    begin
      case (a)
        `SYS_CSR_MSTATUS:  m_mstatus  = d;
        `SYS_CSR_MIE:      m_mie      = d;
        `SYS_CSR_MTVEC:    m_mtvec    = d;
        `SYS_CSR_MEPC:     m_mepc     = d;
        `SYS_CSR_MCAUSE:   m_mcause   = d;
        `SYS_CSR_MTVAL:    m_mtval    = d;
        `SYS_CSR_MSCRATCH: m_mscratch = d;
        `SYS_CSR_MINSTRET: m_minstret = d;
        default:           ;
      endcase
    end
  endtask

  // trap entry saves state and stacks the interrupt enable.
  task automatic model_take(input logic [63:0] epc, input logic [63:0] cause,
                            input logic [63:0] tval);
    begin
      m_mepc                     = epc;
      m_mcause                   = cause;
      m_mtval                    = tval;
      m_mstatus[status_mpie_bit] = m_mstatus[status_mie_bit];
      m_mstatus[status_mie_bit]  = 1'b0;
    end
  endtask

  // standard machine cause codes, itlb first and dtlb last.
  function automatic logic [63:0] exc_cause(input sys_exc_s e, input logic st);
    if (e.itlb_miss)
      return 64'd12;
    else if (e.illegal)
      return 64'd2;
    else if (e.ebreak)
      return 64'd3;
    else if (e.ecall)
      return 64'd11;
    else
      return st ? 64'd15 : 64'd13;
  endfunction

  function automatic logic [63:0] exc_tval(input sys_exc_s e, input logic [38:0] pc,
                                          input logic [38:0] va);
    if (e.itlb_miss)
      return {25'd0, pc};
    else if (e.illegal || e.ebreak || e.ecall)
      return 64'd0;
    else
      return {25'd0, va};
  endfunction

  // one instruction from dispatch through commit and the redirect cycle.
  task automatic run_instr(input sys_op_e op, input logic [11:0] addr,
                           input logic [63:0] opnd, input sys_exc_s exc, input logic st);
    logic [63:0] noise;
    logic [63:0] tmp;
    logic [63:0] old_val;
    logic [63:0] new_val;
    logic [38:0] pc;
    logic [38:0] npc;
    logic [38:0] vaddr;
    logic [38:0] exp_pc;
    logic        is_imm;
    begin
      noise  = rand64();
      tmp    = rand64();
      pc     = tmp[38:0];
      tmp    = rand64();
      npc    = tmp[38:0];
      tmp    = rand64();
      vaddr  = tmp[38:0];
      is_imm = op inside {e_sys_rwi, e_sys_rsi, e_sys_rci};
      @(posedge clk_i);
      sys_v_i    <= 1'b1;
      sys_op_i   <= op;
      csr_addr_i <= addr;
      rs1_i      <= is_imm ? noise : opnd;
      imm_i      <= is_imm ? opnd : noise;
      store_i    <= st;
      @(posedge clk_i);
      sys_v_i <= 1'b0;
      store_i <= 1'b0;
      @(posedge clk_i);
      commit_v_i        <= 1'b1;
      commit_pc_i       <= pc;
      commit_npc_i      <= npc;
      exception_i       <= exc;
      exception_vaddr_i <= vaddr;
      @(negedge clk_i);
      old_val = model_read(addr);
      if (v_o !== 1'b1)
        report_mismatch("v_o", 64'd1, v_o);
      if (exc == '0 && op != e_sys_mret && data_o !== old_val)
        report_mismatch("data_o", old_val, data_o);
      if (exc_v_o !== (|exc))
        report_mismatch("exc_v_o", |exc, exc_v_o);
      if (itlb_miss_o !== exc.itlb_miss)
        report_mismatch("itlb_miss_o", exc.itlb_miss, itlb_miss_o);
      if (load_miss_o !== (exc.dtlb_miss & ~st))
        report_mismatch("load_miss_o", exc.dtlb_miss & ~st, load_miss_o);
      if (store_miss_o !== (exc.dtlb_miss & st))
        report_mismatch("store_miss_o", exc.dtlb_miss & st, store_miss_o);
      if ((exc.itlb_miss || exc.dtlb_miss) &&
          miss_vaddr_o !== (exc.itlb_miss ? pc : vaddr))
        report_mismatch("miss_vaddr_o", exc.itlb_miss ? pc : vaddr, miss_vaddr_o);
      case (op)
        e_sys_rs, e_sys_rsi: new_val = old_val | opnd;
        e_sys_rc, e_sys_rci: new_val = old_val & ~opnd;
        default:             new_val = opnd;
      endcase
      exp_pc = (exc != '0) ? m_mtvec[38:0] : m_mepc[38:0];
      if (exc != '0)
        model_take({25'd0, pc}, exc_cause(exc, st), exc_tval(exc, pc, vaddr));
      else
      begin
        m_minstret = m_minstret + 64'd1;
        m_last_npc = {25'd0, npc};
        if (op == e_sys_mret)
          m_mstatus[status_mie_bit] = m_mstatus[status_mpie_bit];
        else
          model_write(addr, new_val);   // a csr write beats the count.
      end
      @(posedge clk_i);
      commit_v_i  <= 1'b0;
      exception_i <= '0;
      @(negedge clk_i);
      if (miss_v_o !== (exc != '0))
        report_mismatch("miss_v_o", exc != '0, miss_v_o);
      if (exc != '0 || op == e_sys_mret)
      begin
        if (trap_v_o !== 1'b1)
          report_mismatch("trap_v_o", 64'd1, trap_v_o);
        if (trap_pc_o !== exp_pc)
          report_mismatch("trap_pc_o", exp_pc, trap_pc_o);
      end
      else if (trap_v_o !== 1'b0)
        report_mismatch("trap_v_o", 64'd0, trap_v_o);
    end
  endtask

  task automatic read_csr(input logic [11:0] addr);
    begin
      run_instr(e_sys_rs, addr, 64'h0, '0, 1'b0);
    end
  endtask

  task automatic flush_in_flight(input logic two);
    begin
      @(posedge clk_i);
      sys_v_i    <= 1'b1;
      sys_op_i   <= e_sys_rw;
      csr_addr_i <= `SYS_CSR_MSCRATCH;
      rs1_i      <= rand64();
      @(posedge clk_i);
      sys_v_i    <= two;              // second one sits on the dispatch port.
      csr_addr_i <= `SYS_CSR_MTVEC;
      rs1_i      <= rand64();
      flush_i    <= 1'b1;
      @(posedge clk_i);
      sys_v_i <= 1'b0;
      flush_i <= 1'b0;
      repeat (3)
      begin
        @(negedge clk_i);
        if (v_o !== 1'b0)
          report_mismatch("v_o", 64'd0, v_o);
      end
      read_csr(`SYS_CSR_MSCRATCH);
      read_csr(`SYS_CSR_MTVEC);
    end
  endtask

  task automatic irq_then_mret();
    logic [31:0] r;
    logic [63:0] tmp;
    logic [2:0]  lines;
    logic [3:0]  code;
    integer      n;
    begin
      run_instr(e_sys_rw, `SYS_CSR_MTVEC, rand64(), '0, 1'b0);
      run_instr(e_sys_rw, `SYS_CSR_MIE, 64'h888, '0, 1'b0);
      run_instr(e_sys_rs, `SYS_CSR_MSTATUS, 64'h8, '0, 1'b0);
      r     = $random(seed);
      lines = (r[2:0] == 3'd0) ? 3'b001 : r[2:0];
      code  = lines[2] ? 4'd11 : (lines[1] ? 4'd3 : 4'd7);
      @(posedge clk_i);
      mem_ready_i    <= 1'b0;
      timer_irq_i    <= lines[0];
      software_irq_i <= lines[1];
      external_irq_i <= lines[2];
      n = 0;
      @(negedge clk_i);
      while (ready_o !== 1'b0 && n < 20)
      begin
        @(negedge clk_i);
        n = n + 1;
      end
      if (ready_o !== 1'b0)
      begin
        timeouts = timeouts + 1;
        $display("timeout waiting for ready_o to drop after an interrupt line rose");
      end
      if (trap_v_o !== 1'b0)
        report_mismatch("trap_v_o", 64'd0, trap_v_o);
      tmp = rand64();
      @(posedge clk_i);
      mem_ready_i  <= 1'b1;
      commit_v_i   <= 1'b1;           // a retiring instruction holds the interrupt off.
      commit_npc_i <= tmp[38:0];
      m_minstret   = m_minstret + 64'd1;
      m_last_npc   = {25'd0, tmp[38:0]};
      @(posedge clk_i);
      commit_v_i <= 1'b0;
      @(negedge clk_i);
      if (trap_v_o !== 1'b0)
        report_mismatch("trap_v_o", 64'd0, trap_v_o);
      n = 0;
      @(negedge clk_i);
      while (trap_v_o !== 1'b1 && n < 20)
      begin
        @(negedge clk_i);
        n = n + 1;
      end
      if (trap_v_o !== 1'b1)
      begin
        timeouts = timeouts + 1;
        $display("timeout waiting for the interrupt redirect");
      end
      else if (trap_pc_o !== m_mtvec[38:0])
        report_mismatch("trap_pc_o", m_mtvec[38:0], trap_pc_o);
      if (ready_o !== 1'b1)
        report_mismatch("ready_o", 64'd1, ready_o);
      model_take(m_last_npc, {1'b1, 59'd0, code}, 64'd0);
      @(posedge clk_i);
      timer_irq_i    <= 1'b0;
      software_irq_i <= 1'b0;
      external_irq_i <= 1'b0;
      read_csr(`SYS_CSR_MCAUSE);
      read_csr(`SYS_CSR_MEPC);
      read_csr(`SYS_CSR_MTVAL);
      read_csr(`SYS_CSR_MSTATUS);
      run_instr(e_sys_mret, `SYS_CSR_MSTATUS, 64'h0, '0, 1'b0);
      read_csr(`SYS_CSR_MSTATUS);
    end
  endtask

  initial
  begin
    sys_exc_s    exc;
    logic [31:0] r;
    logic [63:0] opnd;
    sys_op_e     op;
    logic [11:0] addr;
    integer      i;
    integer      a;
    seed              = 21189;
    mismatches        = 0;
    timeouts          = 0;
    m_mstatus         = '0;
    m_mie             = '0;
    m_mtvec           = '0;
    m_mepc            = '0;
    m_mcause          = '0;
    m_mtval           = '0;
    m_mscratch        = '0;
    m_minstret        = '0;
    m_last_npc        = '0;
    rst_n_i           = 1'b0;
    sys_v_i           = 1'b0;
    sys_op_i          = e_sys_rw;
    csr_addr_i        = '0;
    rs1_i             = '0;
    imm_i             = '0;
    store_i           = 1'b0;
    flush_i           = 1'b0;
    mem_ready_i       = 1'b1;
    commit_v_i        = 1'b0;
    commit_pc_i       = '0;
    commit_npc_i      = '0;
    exception_i       = '0;
    exception_vaddr_i = '0;
    timer_irq_i       = 1'b0;
    software_irq_i    = 1'b0;
    external_irq_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    if ({v_o, exc_v_o, miss_v_o, trap_v_o, itlb_miss_o, load_miss_o, store_miss_o} !== 7'd0)
      report_mismatch("outputs in reset", 64'd0,
                      {v_o, exc_v_o, miss_v_o, trap_v_o, itlb_miss_o, load_miss_o, store_miss_o});
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    read_csr(`SYS_CSR_MSTATUS);
    read_csr(`SYS_CSR_MIE);
    read_csr(`SYS_CSR_MINSTRET);
    read_csr(12'h7c0);   // unmapped address.
    for (i = 0; i < 24; i = i + 1)
    begin
      op   = pick_op({$random(seed)} % 6);
      a    = {$random(seed)} % 3;
      addr = (a == 0) ? `SYS_CSR_MSCRATCH : ((a == 1) ? `SYS_CSR_MTVEC : `SYS_CSR_MIE);
      opnd = rand64();
      if (op inside {e_sys_rwi, e_sys_rsi, e_sys_rci})
        opnd = {59'd0, opnd[4:0]};
      run_instr(op, addr, opnd, '0, 1'b0);
      read_csr(addr);
    end
    flush_in_flight(1'b0);
    flush_in_flight(1'b1);
    for (i = 0; i < 11; i = i + 1)
    begin
      exc = '0;
      r   = $random(seed);
      case (i)
        0:       exc.dtlb_miss = 1'b1;
        1:       exc.dtlb_miss = 1'b1;
        2:       exc.itlb_miss = 1'b1;
        default: exc = (r[4:0] == 5'd0) ? 5'b10000 : r[4:0];
      endcase
      run_instr(e_sys_rw, `SYS_CSR_MSCRATCH, rand64(), exc,
                (i == 0) ? 1'b1 : ((i == 1) ? 1'b0 : r[8]));
      read_csr(`SYS_CSR_MCAUSE);
      read_csr(`SYS_CSR_MEPC);
      read_csr(`SYS_CSR_MTVAL);
      read_csr(`SYS_CSR_MSCRATCH);
    end
    irq_then_mret();
    read_csr(`SYS_CSR_MINSTRET);
    read_csr(`SYS_CSR_MINSTRET);
    $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches + timeouts == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- verilog/sys_pipe.sv
/*
  System pipe top level. Connects the command stage, the CSR file and
  the trap controller through the command and trap interfaces; the
  rest of the back end sees plain ports only.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

module sys_pipe (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sys_v_i,
  input  sys_pipe_pkg::sys_op_e      sys_op_i,
  input  logic [`SYS_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`SYS_XLEN-1:0]       rs1_i,
  input  logic [`SYS_XLEN-1:0]       imm_i,
  input  logic                       store_i,
  input  logic                       flush_i,
  input  logic                       mem_ready_i,
  input  logic                       commit_v_i,
  input  logic [`SYS_VADDR_W-1:0]    commit_pc_i,
  input  logic [`SYS_VADDR_W-1:0]    commit_npc_i,
  input  sys_pipe_pkg::sys_exc_s     exception_i,
  input  logic [`SYS_VADDR_W-1:0]    exception_vaddr_i,
  input  logic                       timer_irq_i,
  input  logic                       software_irq_i,
  input  logic                       external_irq_i,
  output logic                       ready_o,
  output logic                       v_o,
  output logic [`SYS_XLEN-1:0]       data_o,
  output logic                       exc_v_o,
  output logic                       miss_v_o,
  output logic                       itlb_miss_o,
  output logic                       load_miss_o,
  output logic                       store_miss_o,
  output logic [`SYS_VADDR_W-1:0]    miss_vaddr_o,
  output logic                       trap_v_o,
  output logic [`SYS_VADDR_W-1:0]    trap_pc_o
);

  sys_cmd_if  cmd_if ();
  sys_trap_if trap_if ();

  sys_cmd_stage u_cmd_stage (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .sys_v_i           (sys_v_i),
    .sys_op_i          (sys_op_i),
    .csr_addr_i        (csr_addr_i),
    .rs1_i             (rs1_i),
    .imm_i             (imm_i),
    .store_i           (store_i),
    .flush_i           (flush_i),
    .commit_v_i        (commit_v_i),
    .exception_i       (exception_i),
    .commit_pc_i       (commit_pc_i),
    .exception_vaddr_i (exception_vaddr_i),
    .cmd               (cmd_if),
    .v_o               (v_o),
    .itlb_miss_o       (itlb_miss_o),
    .load_miss_o       (load_miss_o),
    .store_miss_o      (store_miss_o),
    .miss_vaddr_o      (miss_vaddr_o)
  );

  sys_csr_file u_csr_file (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd            (cmd_if),
    .trap           (trap_if),
    .commit_v_i     (commit_v_i),
    .timer_irq_i    (timer_irq_i),
    .software_irq_i (software_irq_i),
    .external_irq_i (external_irq_i),
    .data_o         (data_o)
  );

  sys_trap_ctrl u_trap_ctrl (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .cmd               (cmd_if),
    .trap              (trap_if),
    .commit_v_i        (commit_v_i),
    .commit_pc_i       (commit_pc_i),
    .commit_npc_i      (commit_npc_i),
    .exception_vaddr_i (exception_vaddr_i),
    .mem_ready_i       (mem_ready_i),
    .ready_o           (ready_o),
    .exc_v_o           (exc_v_o),
    .trap_v_o          (trap_v_o),
    .trap_pc_o         (trap_pc_o),
    .miss_v_o          (miss_v_o)
  );

endmodule

//--- verilog/sys_trap_ctrl.sv
/*
  Trap controller. Picks the exception cause at commit, takes a pending
  interrupt when nothing commits, recognises MRET, and registers the
  redirect that goes to the front end one cycle later.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

module sys_trap_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  sys_cmd_if.trap                 cmd,
  sys_trap_if.ctrl                trap,
  input  logic                    commit_v_i,
  input  logic [`SYS_VADDR_W-1:0] commit_pc_i,
  input  logic [`SYS_VADDR_W-1:0] commit_npc_i,
  input  logic [`SYS_VADDR_W-1:0] exception_vaddr_i,
  input  logic                    mem_ready_i,
  output logic                    ready_o,
  output logic                    exc_v_o,
  output logic                    trap_v_o,
  output logic [`SYS_VADDR_W-1:0] trap_pc_o,
  output logic                    miss_v_o
);
  import sys_pipe_pkg::*;

  logic                    irq_ready;
  logic                    irq_take;
  logic                    exc_take;
  logic                    mret_take;
  sys_cause_e              exc_cause;
  sys_cause_e              irq_cause;
  logic [`SYS_XLEN-1:0]    exc_tval;
  logic [`SYS_VADDR_W-1:0] last_npc_r;
  logic                    trap_v_r;
  logic                    miss_v_r;
  logic [`SYS_VADDR_W-1:0] trap_pc_r;

  assign irq_ready = trap.status.f.mie & (|trap.irq_pend);
  assign irq_take  = irq_ready & mem_ready_i & ~commit_v_i & ~trap_v_r; // wait out a redirect.
  assign exc_take  = cmd.kill;
  assign mret_take = cmd.v & commit_v_i & ~cmd.kill & (cmd.op == e_sys_mret);

  // priority itlb, illegal, ebreak, ecall, dtlb.
  always_comb
  begin
    exc_tval = '0;
    if (cmd.exc.itlb_miss)
    begin
      exc_cause = e_cause_itlb;
      exc_tval  = {{(`SYS_XLEN-`SYS_VADDR_W){1'b0}}, commit_pc_i};
    end
    else if (cmd.exc.illegal)
      exc_cause = e_cause_illegal;
    else if (cmd.exc.ebreak)
      exc_cause = e_cause_ebreak;
    else if (cmd.exc.ecall)
      exc_cause = e_cause_ecall_m;
    else
    begin
      exc_cause = cmd.is_store ? e_cause_store_tlb : e_cause_load_tlb;
      exc_tval  = {{(`SYS_XLEN-`SYS_VADDR_W){1'b0}}, exception_vaddr_i};
    end
  end

  always_comb
  begin
    if (trap.irq_pend[`SYS_MEI_BIT])
      irq_cause = e_cause_mei;
    else if (trap.irq_pend[`SYS_MSI_BIT])
      irq_cause = e_cause_msi;
    else
      irq_cause = e_cause_mti;
  end

  assign trap.take_v = exc_take | irq_take;
  assign trap.mret_v = mret_take;
  assign trap.cause  = exc_take ? exc_cause : irq_cause;
  assign trap.epc    = exc_take ? commit_pc_i : last_npc_r; // interrupts resume after the last retire.
  assign trap.tval   = exc_take ? exc_tval : '0;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      trap_v_r   <= 1'b0;
      miss_v_r   <= 1'b0;
      last_npc_r <= '0;
    end
    else
    begin
      trap_v_r <= trap.take_v | mret_take;
      miss_v_r <= trap.take_v;
      if (commit_v_i && !cmd.kill)
        last_npc_r <= commit_npc_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    trap_pc_r <= mret_take ? trap.mepc : trap.mtvec;
  end

  assign ready_o   = ~irq_ready;
  assign exc_v_o   = exc_take;
  assign trap_v_o  = trap_v_r;
  assign trap_pc_o = trap_pc_r;
  assign miss_v_o  = miss_v_r;

  single_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_v_o |=> !trap_v_o)
    else $error("trap_v_o high on two cycles in a row");

endmodule

//--- verilog/sys_csr_file.sv
/*
  Machine-mode CSR file. Returns the addressed CSR in the commit cycle
  and applies write, set or clear on the closing edge. Trap and MRET
  strobes from the trap controller update the trap CSRs and stack the
  interrupt enable. Interrupt lines are sampled into mip every cycle.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

module sys_csr_file (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  sys_cmd_if.csr               cmd,
  sys_trap_if.csr              trap,
  input  logic                 commit_v_i,
  input  logic                 timer_irq_i,
  input  logic                 software_irq_i,
  input  logic                 external_irq_i,
  output logic [`SYS_XLEN-1:0] data_o
);
  import sys_pipe_pkg::*;

  sys_status_u          mstatus_r;
  logic [`SYS_XLEN-1:0] mie_r;
  logic [`SYS_XLEN-1:0] mip_r;
  logic [`SYS_XLEN-1:0] mtvec_r;
  logic [`SYS_XLEN-1:0] mepc_r;
  logic [`SYS_XLEN-1:0] mcause_r;
  logic [`SYS_XLEN-1:0] mtval_r;
  logic [`SYS_XLEN-1:0] mscratch_r;
  logic [`SYS_XLEN-1:0] minstret_r;
  logic [`SYS_XLEN-1:0] rdata;
  logic [`SYS_XLEN-1:0] wdata;
  logic [`SYS_XLEN-1:0] cause_word;
  logic                 csr_we;
  logic                 retire;

  always_comb
  begin
    case (cmd.addr)
      `SYS_CSR_MSTATUS:  rdata = mstatus_r.raw;
      `SYS_CSR_MIE:      rdata = mie_r;
      `SYS_CSR_MIP:      rdata = mip_r;
      `SYS_CSR_MTVEC:    rdata = mtvec_r;
      `SYS_CSR_MEPC:     rdata = mepc_r;
      `SYS_CSR_MCAUSE:   rdata = mcause_r;
      `SYS_CSR_MTVAL:    rdata = mtval_r;
      `SYS_CSR_MSCRATCH: rdata = mscratch_r;
      `SYS_CSR_MINSTRET: rdata = minstret_r;
      default:           rdata = '0;
    endcase
  end

  always_comb
  begin
    case (cmd.op)
      e_sys_rs, e_sys_rsi: wdata = rdata | cmd.data;
      e_sys_rc, e_sys_rci: wdata = rdata & ~cmd.data;
      default:             wdata = cmd.data;
    endcase
  end

  // interrupt flag moves up to the top bit of mcause.
  always_comb
  begin
    cause_word                     = '0;
    cause_word[`SYS_IRQ_CAUSE_BIT] = trap.cause[`SYS_CAUSE_W-1];
    cause_word[3:0]                = trap.cause[3:0];
  end

  assign csr_we = cmd.v & commit_v_i & ~cmd.kill & (cmd.op != e_sys_mret);
  assign retire = commit_v_i & ~cmd.kill;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mstatus_r  <= '0;
      mie_r      <= '0;
      mip_r      <= '0;
      mtvec_r    <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
      mscratch_r <= '0;
      minstret_r <= '0;
    end
    else
    begin
      mip_r                <= '0;
      mip_r[`SYS_MSI_BIT]  <= software_irq_i;
      mip_r[`SYS_MTI_BIT]  <= timer_irq_i;
      mip_r[`SYS_MEI_BIT]  <= external_irq_i;
      minstret_r           <= minstret_r + {{(`SYS_XLEN-1){1'b0}}, retire};
      if (trap.take_v)
      begin
        mepc_r            <= {{(`SYS_XLEN-`SYS_VADDR_W){1'b0}}, trap.epc};
        mcause_r          <= cause_word;
        mtval_r           <= trap.tval;
        mstatus_r.f.mpie  <= mstatus_r.f.mie;
        mstatus_r.f.mie   <= 1'b0;
      end
      else if (trap.mret_v)
      begin
        mstatus_r.f.mie <= mstatus_r.f.mpie;
      end
      if (csr_we)
      begin
        case (cmd.addr)
          `SYS_CSR_MSTATUS:  mstatus_r.raw <= wdata;
          `SYS_CSR_MIE:      mie_r         <= wdata;
          `SYS_CSR_MTVEC:    mtvec_r       <= wdata;
          `SYS_CSR_MEPC:     mepc_r        <= wdata;
          `SYS_CSR_MCAUSE:   mcause_r      <= wdata;
          `SYS_CSR_MTVAL:    mtval_r       <= wdata;
          `SYS_CSR_MSCRATCH: mscratch_r    <= wdata;
          `SYS_CSR_MINSTRET: minstret_r    <= wdata; // write wins over the count.
          default:           ;
        endcase
      end
    end
  end

  assign data_o        = rdata;
  assign trap.status   = mstatus_r;
  assign trap.mtvec    = mtvec_r[`SYS_VADDR_W-1:0];
  assign trap.mepc     = mepc_r[`SYS_VADDR_W-1:0];
  assign trap.irq_pend = mip_r & mie_r;

  take_without_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(trap.take_v && csr_we))
    else $error("trap taken in the same cycle as a CSR write");

endmodule

//--- verilog/sys_cmd_stage.sv
/*
  Front half of the system pipe. Selects the CSR operand, carries the
  command two stages to commit, drops it on flush, and attaches the
  exception of the committing instruction. DTLB misses are split into
  load and store misses by the store flag that travels with the command.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

module sys_cmd_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sys_v_i,
  input  sys_pipe_pkg::sys_op_e      sys_op_i,
  input  logic [`SYS_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`SYS_XLEN-1:0]       rs1_i,
  input  logic [`SYS_XLEN-1:0]       imm_i,
  input  logic                       store_i,
  input  logic                       flush_i,
  input  logic                       commit_v_i,
  input  sys_pipe_pkg::sys_exc_s     exception_i,
  input  logic [`SYS_VADDR_W-1:0]    commit_pc_i,
  input  logic [`SYS_VADDR_W-1:0]    exception_vaddr_i,
  sys_cmd_if.stage                   cmd,
  output logic                       v_o,
  output logic                       itlb_miss_o,
  output logic                       load_miss_o,
  output logic                       store_miss_o,
  output logic [`SYS_VADDR_W-1:0]    miss_vaddr_o
);
  import sys_pipe_pkg::*;

  logic                       v_s1_r;
  logic                       v_s2_r;
  sys_op_e                    op_s1_r;
  sys_op_e                    op_s2_r;
  logic [`SYS_CSR_ADDR_W-1:0] addr_s1_r;
  logic [`SYS_CSR_ADDR_W-1:0] addr_s2_r;
  logic [`SYS_XLEN-1:0]       data_s1_r;
  logic [`SYS_XLEN-1:0]       data_s2_r;
  logic                       store_s1_r;
  logic                       store_s2_r;
  logic                       use_imm;
  logic [`SYS_XLEN-1:0]       operand;
  sys_exc_s                   exc_c;

  assign use_imm = sys_op_i inside {e_sys_rwi, e_sys_rsi, e_sys_rci};
  assign operand = use_imm ? imm_i : rs1_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      v_s1_r <= 1'b0;
      v_s2_r <= 1'b0;
    end
    else
    begin
      v_s1_r <= sys_v_i;
      v_s2_r <= v_s1_r;
    end
  end

  // store flag follows every dispatch, not only CSR ones.
  always_ff @(posedge clk_i)
  begin
    op_s1_r    <= sys_op_i;
    op_s2_r    <= op_s1_r;
    addr_s1_r  <= csr_addr_i;
    addr_s2_r  <= addr_s1_r;
    data_s1_r  <= operand;
    data_s2_r  <= data_s1_r;
    store_s1_r <= store_i;
    store_s2_r <= store_s1_r;
  end

  assign exc_c = commit_v_i ? exception_i : '0;

  assign cmd.v        = v_s2_r;
  assign cmd.op       = op_s2_r;
  assign cmd.addr     = addr_s2_r;
  assign cmd.data     = data_s2_r;
  assign cmd.exc      = exc_c;
  assign cmd.is_store = store_s2_r;
  assign cmd.kill     = |exc_c;

  assign v_o          = v_s2_r;
  assign itlb_miss_o  = exc_c.itlb_miss;
  assign load_miss_o  = exc_c.dtlb_miss & ~store_s2_r;
  assign store_miss_o = exc_c.dtlb_miss & store_s2_r;
  assign miss_vaddr_o = exc_c.itlb_miss ? commit_pc_i : exception_vaddr_i; // fetch misses on the pc.

  flush_drops_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !v_o)
    else $error("v_o raised in the cycle after flush_i");

endmodule

//--- verilog/sys_trap_if.sv
/*
  Trap decisions from the trap controller to the CSR file, and the
  trap state the CSR file returns to steer those decisions.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

interface sys_trap_if;
  import sys_pipe_pkg::*;

  logic                    take_v;    // exception or interrupt taken this cycle.
  logic                    mret_v;
  sys_cause_e              cause;
  logic [`SYS_VADDR_W-1:0] epc;
  logic [`SYS_XLEN-1:0]    tval;

  sys_status_u             status;
  logic [`SYS_VADDR_W-1:0] mtvec;
  logic [`SYS_VADDR_W-1:0] mepc;
  logic [`SYS_XLEN-1:0]    irq_pend;  // mip masked by mie.

  modport ctrl (
    output take_v, mret_v, cause, epc, tval,
    input  status, mtvec, mepc, irq_pend
  );

  modport csr (
    input  take_v, mret_v, cause, epc, tval,
    output status, mtvec, mepc, irq_pend
  );

endinterface

//--- verilog/sys_cmd_if.sv
/*
  Committed CSR command, driven by the command stage and read by the
  CSR file and the trap controller in the commit cycle.
*/
`timescale 1ns/100ps
`include "sys_pipe_defines.svh"

interface sys_cmd_if;
  import sys_pipe_pkg::*;

  logic                       v;        // command sits in the commit slot.
  sys_op_e                    op;
  logic [`SYS_CSR_ADDR_W-1:0] addr;
  logic [`SYS_XLEN-1:0]       data;     // rs1 or zero-extended immediate.
  sys_exc_s                   exc;
  logic                       is_store;
  logic                       kill;     // committing instruction raised an exception.

  modport stage (
    output v, op, addr, data, exc, is_store, kill
  );

  modport csr (
    input v, op, addr, data, kill
  );

  modport trap (
    input v, op, exc, is_store, kill
  );

endinterface

//--- verilog/sys_pipe_pkg.sv
/*
  Types shared by the system pipe: CSR operations, exception flags,
  the mstatus word and the trap cause codes.
*/
`include "sys_pipe_defines.svh"

package sys_pipe_pkg;

  typedef enum logic [`SYS_OP_W-1:0]
  {
    e_sys_rw   = 3'd0,
    e_sys_rs   = 3'd1,
    e_sys_rc   = 3'd2,
    e_sys_rwi  = 3'd3,
    e_sys_rsi  = 3'd4,
    e_sys_rci  = 3'd5,
    e_sys_mret = 3'd6
  } sys_op_e;

  typedef struct packed
  {
    logic illegal;
    logic ecall;
    logic ebreak;
    logic itlb_miss;
    logic dtlb_miss;
  } sys_exc_s;

  // mstatus seen as a whole word or as the machine-mode fields.
  typedef union packed
  {
    logic [`SYS_XLEN-1:0] raw;
    struct packed
    {
      logic [50:0] rsvd_hi;
      logic [1:0]  mpp;
      logic [2:0]  rsvd_mid;
      logic        mpie;
      logic [2:0]  rsvd_lo;
      logic        mie;
      logic [2:0]  rsvd_low;
    } f;
  } sys_status_u;

  typedef enum logic [`SYS_CAUSE_W-1:0]
  {
    e_cause_illegal   = 5'h02,
    e_cause_ebreak    = 5'h03,
    e_cause_ecall_m   = 5'h0b,
    e_cause_itlb      = 5'h0c,
    e_cause_load_tlb  = 5'h0d,
    e_cause_store_tlb = 5'h0f,
    e_cause_msi       = 5'h13,
    e_cause_mti       = 5'h17,
    e_cause_mei       = 5'h1b
  } sys_cause_e;

endpackage

//--- include/sys_pipe_defines.svh
/*
  Widths, CSR address codes and mip bit positions for the system pipe.
  Included by the package and by every file that sizes a port or a register.
*/
`ifndef SYS_PIPE_DEFINES_SVH
`define SYS_PIPE_DEFINES_SVH

`define SYS_XLEN           64
`define SYS_VADDR_W        39
`define SYS_CSR_ADDR_W     12
`define SYS_OP_W           3
`define SYS_CAUSE_W        5     // msb flags an interrupt, low 4 bits are the code.

`define SYS_CSR_MSTATUS    12'h300
`define SYS_CSR_MIE        12'h304
`define SYS_CSR_MTVEC      12'h305
`define SYS_CSR_MSCRATCH   12'h340
`define SYS_CSR_MEPC       12'h341
`define SYS_CSR_MCAUSE     12'h342
`define SYS_CSR_MTVAL      12'h343
`define SYS_CSR_MIP        12'h344
`define SYS_CSR_MINSTRET   12'hb02

`define SYS_IRQ_CAUSE_BIT  63
`define SYS_MSI_BIT        3
`define SYS_MTI_BIT        7
`define SYS_MEI_BIT        11

`endif
